//--- project.f
common/rv_mem_pkg.sv
common/axi_lite_pkg.sv
common/axi_lite_if.sv
lsu/load_align.sv
lsu/store_mask_gen.sv
lsu/mem_access_ctrl.sv
hdl/sram_axi_lite.sv
hdl/mem_stage_top.sv
test/mem_stage_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the memory stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
{ verilator --binary --assert --top-module mem_stage_tb -f project.f -o mem_stage_sim &&
    ./obj_dir/mem_stage_sim; } > sim.log 2>&1
grep -qx "TEST RESULT: PASS" sim.log && echo "Simulation passed" ||
    { echo "Simulation failed, see sim.log"; exit 1; }

//--- test/mem_stage_tb.sv
`timescale 1ns/1ps

module mem_stage_tb;

    localparam int NUM_FILL   = 32;
    localparam int NUM_RANDOM = 300;
    // A load with a full stall and an idle gap stays well under 18 cycles
    localparam int MAX_CYCLES = (NUM_FILL + NUM_RANDOM) * 18;

    typedef struct packed {
        rv_mem_pkg::word_t     pc;
        rv_mem_pkg::word_t     inst;
        rv_mem_pkg::word_t     result;
        rv_mem_pkg::reg_addr_t rd;
        logic                  is_load;
        rv_mem_pkg::word_t     load_data;
    } expect_t;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  in_valid_i;
    logic                  in_ready_o;
    rv_mem_pkg::word_t     pc_i;
    rv_mem_pkg::word_t     inst_i;
    rv_mem_pkg::word_t     result_i;
    rv_mem_pkg::word_t     dmem_addr_i;
    rv_mem_pkg::word_t     rs2_data_i;
    rv_mem_pkg::reg_addr_t rd_addr_i;
    logic                  out_valid_o;
    logic                  out_ready_i;
    rv_mem_pkg::word_t     pc_o;
    rv_mem_pkg::word_t     inst_o;
    rv_mem_pkg::word_t     result_o;
    rv_mem_pkg::reg_addr_t rd_addr_o;
    rv_mem_pkg::word_t     load_data_o;

    int                    seed;
    int                    cycle_count = 0;
    int                    stall_left = 0;
    rv_mem_pkg::word_t     shadow [256];
    expect_t               exp_q [$];
    expect_t               head;
    logic                  head_valid = 1'b0;
    logic                  in_hs;
    logic                  in_is_store;
    logic                  in_is_mem;

    mem_stage_top UUT (.*);

    always #5 clk = ~clk;

    assign in_hs       = in_valid_i && in_ready_o;
    assign in_is_store = (inst_i[6:0] == rv_mem_pkg::OPCODE_STORE);
    assign in_is_mem   = in_is_store || (inst_i[6:0] == rv_mem_pkg::OPCODE_LOAD);

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES)
            report_failure("Timeout: the stage did not finish all bundles in time");
    end

    task automatic refresh_head();
        head_valid = (exp_q.size() != 0);
        if (head_valid) begin
            head = exp_q[0];
        end
    endtask

    // Retire the oldest bundle on each output handshake
    always @(posedge clk) begin
        if (!rst && out_valid_o && out_ready_i) begin
            if (exp_q.size() != 0) begin
                exp_q.delete(0);
            end
            refresh_head();
        end
    end

    // Lane selection and extension of a load from the shadow word
    function automatic rv_mem_pkg::word_t expected_load(input rv_mem_pkg::word_t word,
            input logic [1:0] off, input logic [2:0] f3);
        logic [7:0]  lanes [4];
        logic [15:0] half;
        for (int i = 0; i < 4; i++) begin
            lanes[i] = word[8*i +: 8];
        end
        half = {lanes[off + 2'd1], lanes[off]};
        case (f3)
            3'b000:  return {{24{lanes[off][7]}}, lanes[off]};
            3'b100:  return {24'h0, lanes[off]};
            3'b001:  return {{16{half[15]}}, half};
            3'b101:  return {16'h0, half};
            default: return word;
        endcase
    endfunction

    // Only the addressed lanes take the low bytes of rs2
    task automatic apply_store(input rv_mem_pkg::word_t addr, input rv_mem_pkg::word_t data,
            input logic [2:0] f3);
        int nbytes;
        int base;
        nbytes = (f3 == 3'b000) ? 1 : (f3 == 3'b001) ? 2 : 4;
        base = int'(addr[1:0]);
        for (int i = 0; i < nbytes; i++) begin
            shadow[addr[9:2]][8*(base+i) +: 8] = data[8*i +: 8];
        end
    endtask

    function automatic rv_mem_pkg::word_t word_address(input int k);
        return rv_mem_pkg::word_t'((k * 8 + 3) * 4);
    endfunction

    function automatic rv_mem_pkg::word_t make_inst(input rv_mem_pkg::word_t raw,
            input logic [6:0] opcode, input logic [2:0] f3);
        return {raw[31:15], f3, raw[11:7], opcode};
    endfunction

    // One clock step with random stretches of writeback back-pressure
    task automatic next_cycle();
        @(posedge clk);
        #1;
        if (stall_left > 0) begin
            stall_left--;
            out_ready_i = 1'b0;
        end else if (($unsigned($random(seed)) % 6) == 0) begin
            stall_left = 1 + int'($unsigned($random(seed)) % 6);
            out_ready_i = 1'b0;
        end else begin
            out_ready_i = 1'b1;
        end
    endtask

    task automatic record_bundle();
        expect_t    e;
        logic [2:0] f3;
        f3 = inst_i[rv_mem_pkg::FUNCT3_MSB:rv_mem_pkg::FUNCT3_LSB];
        e.pc = pc_i;
        e.inst = inst_i;
        e.result = result_i;
        e.rd = rd_addr_i;
        e.is_load = (inst_i[6:0] == rv_mem_pkg::OPCODE_LOAD);
        e.load_data = '0;
        if (e.is_load) begin
            e.load_data = expected_load(shadow[dmem_addr_i[9:2]], dmem_addr_i[1:0], f3);
        end
        if (inst_i[6:0] == rv_mem_pkg::OPCODE_STORE) begin
            apply_store(dmem_addr_i, rs2_data_i, f3);
        end
        exp_q.push_back(e);
        refresh_head();
    endtask

    task automatic send_bundle(input rv_mem_pkg::word_t inst, input rv_mem_pkg::word_t addr,
            input rv_mem_pkg::word_t rs2);
        logic accepted;
        pc_i = $random(seed);
        result_i = $random(seed);
        rd_addr_i = rv_mem_pkg::reg_addr_t'($random(seed));
        inst_i = inst;
        dmem_addr_i = addr;
        rs2_data_i = rs2;
        in_valid_i = 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            // in_ready_o only moves at a clock edge
            accepted = in_ready_o;
            if (accepted) begin
                record_bundle();
            end
            next_cycle();
        end
        in_valid_i = 1'b0;
    endtask

    task automatic random_bundle();
        int unsigned kind;
        int unsigned widx;
        logic [1:0]  off;
        logic [2:0]  f3;
        logic [6:0]  opcode;
        kind = $unsigned($random(seed)) % 10;
        widx = $unsigned($random(seed)) % NUM_FILL;
        off = 2'($random(seed));
        f3 = 3'b010;
        opcode = 7'b0010011;
        if (kind < 4) begin
            opcode = rv_mem_pkg::OPCODE_LOAD;
            case ($unsigned($random(seed)) % 5)
                0:       f3 = 3'b000;
                1:       f3 = 3'b001;
                2:       f3 = 3'b010;
                3:       f3 = 3'b100;
                default: f3 = 3'b101;
            endcase
        end else if (kind < 8) begin
            opcode = rv_mem_pkg::OPCODE_STORE;
            f3 = 3'($unsigned($random(seed)) % 3);
        end
        if (f3 == 3'b001 || f3 == 3'b101) begin
            off[0] = 1'b0;
        end else if (f3 == 3'b010) begin
            off = 2'b00;
        end
        send_bundle(make_inst($random(seed), opcode, f3),
                    word_address(int'(widx)) | {30'h0, off}, $random(seed));
        if (($unsigned($random(seed)) % 4) == 0) begin
            next_cycle();
        end
    endtask

    initial begin
        seed = 32'h70d26c8a;
        rst = 1'b1;
        in_valid_i = 1'b0;
        pc_i = '0;
        inst_i = '0;
        result_i = '0;
        dmem_addr_i = '0;
        rs2_data_i = '0;
        rd_addr_i = '0;
        out_ready_i = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        // Word stores give every word used later a known value
        for (int k = 0; k < NUM_FILL; k++) begin
            send_bundle(make_inst($random(seed), rv_mem_pkg::OPCODE_STORE, 3'b010),
                        word_address(k), $random(seed));
        end
        for (int n = 0; n < NUM_RANDOM; n++) begin
            random_bundle();
        end
        while (exp_q.size() != 0) begin
            next_cycle();
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

    a_reset_state: assert property (@(posedge clk)
        (rst || $fell(rst)) |-> (!out_valid_o && in_ready_o))
        else report_failure("Handshake outputs wrong during or right after reset");

    a_out_known: assert property (@(posedge clk) disable iff (rst) out_valid_o |-> head_valid)
        else report_failure("out_valid_o high with no accepted bundle outstanding");

    a_pc: assert property (@(posedge clk) disable iff (rst)
        (out_valid_o && out_ready_i) |-> pc_o == head.pc)
        else report_failure($sformatf("Mismatch pc_o: got %h, expected %h",
            $sampled(pc_o), $sampled(head.pc)));

    a_inst: assert property (@(posedge clk) disable iff (rst)
        (out_valid_o && out_ready_i) |-> inst_o == head.inst)
        else report_failure($sformatf("Mismatch inst_o: got %h, expected %h",
            $sampled(inst_o), $sampled(head.inst)));

    a_result: assert property (@(posedge clk) disable iff (rst)
        (out_valid_o && out_ready_i) |-> result_o == head.result)
        else report_failure($sformatf("Mismatch result_o: got %h, expected %h",
            $sampled(result_o), $sampled(head.result)));

    a_rd: assert property (@(posedge clk) disable iff (rst)
        (out_valid_o && out_ready_i) |-> rd_addr_o == head.rd)
        else report_failure($sformatf("Mismatch rd_addr_o: got %h, expected %h",
            $sampled(rd_addr_o), $sampled(head.rd)));

    a_load_data: assert property (@(posedge clk) disable iff (rst)
        (out_valid_o && out_ready_i && head.is_load) |-> load_data_o == head.load_data)
        else report_failure($sformatf("Mismatch load_data_o: got %h, expected %h",
            $sampled(load_data_o), $sampled(head.load_data)));

    a_hold_out: assert property (@(posedge clk) disable iff (rst)
        (out_valid_o && !out_ready_i) |=> (out_valid_o && !in_ready_o && $stable(pc_o) &&
            $stable(inst_o) && $stable(result_o) && $stable(rd_addr_o) && $stable(load_data_o)))
        else report_failure("Outputs changed while held under back-pressure");

    a_busy_after_accept: assert property (@(posedge clk) disable iff (rst)
        (in_hs || (!in_ready_o && !(out_valid_o && out_ready_i))) |=> !in_ready_o)
        else report_failure("in_ready_o rose before the output handshake");

    a_ready_after_out: assert property (@(posedge clk) disable iff (rst)
        (out_valid_o && out_ready_i) |=> in_ready_o)
        else report_failure("in_ready_o did not return after the output handshake");

    a_passthrough_time: assert property (@(posedge clk) disable iff (rst)
        (in_hs && !in_is_mem) |=> out_valid_o)
        else report_failure("Non-memory bundle not presented one cycle after acceptance");

    a_store_time: assert property (@(posedge clk) disable iff (rst)
        (in_hs && in_is_store) |=> !out_valid_o ##1 !out_valid_o ##1 out_valid_o)
        else report_failure("Store not presented three cycles after acceptance");

endmodule

//--- hdl/mem_stage_top.sv
`timescale 1ns/1ps

module mem_stage_top (
    input  logic                  clk,
    input  logic                  rst,
    // Execute side
    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    input  rv_mem_pkg::word_t     pc_i,
    input  rv_mem_pkg::word_t     inst_i,
    input  rv_mem_pkg::word_t     result_i,
    input  rv_mem_pkg::word_t     dmem_addr_i,
    input  rv_mem_pkg::word_t     rs2_data_i,
    input  rv_mem_pkg::reg_addr_t rd_addr_i,
    // Writeback side
    output logic                  out_valid_o,
    input  logic                  out_ready_i,
    output rv_mem_pkg::word_t     pc_o,
    output rv_mem_pkg::word_t     inst_o,
    output rv_mem_pkg::word_t     result_o,
    output rv_mem_pkg::reg_addr_t rd_addr_o,
    output rv_mem_pkg::word_t     load_data_o
);

    axi_lite_if dbus ();

    mem_access_ctrl u_mem_access_ctrl (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .pc_i        (pc_i),
        .inst_i      (inst_i),
        .result_i    (result_i),
        .dmem_addr_i (dmem_addr_i),
        .rs2_data_i  (rs2_data_i),
        .rd_addr_i   (rd_addr_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .pc_o        (pc_o),
        .inst_o      (inst_o),
        .result_o    (result_o),
        .rd_addr_o   (rd_addr_o),
        .load_data_o (load_data_o),
        .bus         (dbus.master)
    );

    // Data memory
    sram_axi_lite u_sram (
        .clk (clk),
        .rst (rst),
        .bus (dbus.slave)
    );

endmodule

//--- hdl/sram_axi_lite.sv
`timescale 1ns/1ps

module sram_axi_lite (
    input  logic      clk,
    input  logic      rst,
    axi_lite_if.slave bus
);

    localparam int IDX_W = $clog2(axi_lite_pkg::SRAM_WORDS);
    localparam int CNT_W = $clog2(axi_lite_pkg::SRAM_READ_DELAY + 1);

    rv_mem_pkg::word_t mem [axi_lite_pkg::SRAM_WORDS];

    logic              bvalid_q;
    logic              arready_q;
    logic [CNT_W-1:0]  rd_cnt;
    logic [IDX_W-1:0]  rd_idx_q;
    logic [IDX_W-1:0]  wr_idx;
    logic              idle;
    logic              aw_hs;
    logic              ar_hs;

    // No new request while a response or an ar pulse is outstanding
    assign idle = !bvalid_q && !arready_q && (rd_cnt == '0);

    // aw and w are taken together on one cycle
    assign bus.awready = idle && bus.wvalid;
    assign bus.wready  = idle && bus.awvalid;
    assign aw_hs       = bus.awvalid && bus.awready;

    assign bus.arready = arready_q;
    assign ar_hs       = bus.arvalid && arready_q;

    assign wr_idx = bus.awaddr[IDX_W+1:2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bvalid_q  <= 1'b0;
            arready_q <= 1'b0;
            rd_cnt    <= '0;
        end else begin
            if (aw_hs) begin
                bvalid_q <= 1'b1;
            end else if (bus.bready) begin
                bvalid_q <= 1'b0;
            end

            // One-cycle arready pulse after arvalid is seen
            arready_q <= bus.arvalid && idle;

            if (ar_hs) begin
                rd_cnt <= CNT_W'(axi_lite_pkg::SRAM_READ_DELAY);
            end else if (rd_cnt != '0 && (rd_cnt != CNT_W'(1) || bus.rready)) begin
                rd_cnt <= rd_cnt - CNT_W'(1);
            end
        end
    end

    // Storage and read index
    always_ff @(posedge clk) begin
        if (aw_hs) begin
            for (int i = 0; i < axi_lite_pkg::STRB_W; i++) begin
                if (bus.wstrb[i]) begin
                    mem[wr_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
                end
            end
        end
        if (ar_hs) begin
            rd_idx_q <= bus.araddr[IDX_W+1:2];
        end
    end

    assign bus.bvalid = bvalid_q;
    assign bus.bresp  = axi_lite_pkg::RESP_OKAY;

    // Data is shown on the last count
    assign bus.rvalid = (rd_cnt == CNT_W'(1));
    assign bus.rdata  = mem[rd_idx_q];
    assign bus.rresp  = axi_lite_pkg::RESP_OKAY;

    a_one_in_flight: assert property (@(posedge clk) disable iff (rst)
        (bus.bvalid || rd_cnt != '0) |-> !(aw_hs || ar_hs));

endmodule

//--- lsu/mem_access_ctrl.sv
`timescale 1ns/1ps

module mem_access_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    // Execute side
    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    input  rv_mem_pkg::word_t     pc_i,
    input  rv_mem_pkg::word_t     inst_i,
    input  rv_mem_pkg::word_t     result_i,
    input  rv_mem_pkg::word_t     dmem_addr_i,
    input  rv_mem_pkg::word_t     rs2_data_i,
    input  rv_mem_pkg::reg_addr_t rd_addr_i,
    // Writeback side
    output logic                  out_valid_o,
    input  logic                  out_ready_i,
    output rv_mem_pkg::word_t     pc_o,
    output rv_mem_pkg::word_t     inst_o,
    output rv_mem_pkg::word_t     result_o,
    output rv_mem_pkg::reg_addr_t rd_addr_o,
    output rv_mem_pkg::word_t     load_data_o,
    // Data bus
    axi_lite_if.master            bus
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_RESP,
        DONE
    } state_t;

    state_t                state;
    logic                  aw_done_q;
    logic                  w_done_q;

    rv_mem_pkg::word_t     addr_q;
    rv_mem_pkg::word_t     rs2_q;
    rv_mem_pkg::word_t     load_data_q;
    rv_mem_pkg::word_t     aligned_data;
    rv_mem_pkg::opcode_t   in_opcode;
    rv_mem_pkg::opcode_t   opcode;
    rv_mem_pkg::access_t   access;

    logic                  in_hs;
    logic                  in_is_mem;
    logic                  is_load;
    logic                  is_store;
    logic                  aw_ok;
    logic                  w_ok;
    logic                  misaligned;

    assign in_ready_o  = (state == IDLE);
    assign out_valid_o = (state == DONE);
    assign in_hs       = in_valid_i && in_ready_o;

    // Only the opcode of the incoming bundle is needed to pick the next state
    assign in_opcode = inst_i[rv_mem_pkg::OPCODE_MSB:rv_mem_pkg::OPCODE_LSB];
    assign in_is_mem = (in_opcode == rv_mem_pkg::OPCODE_LOAD) ||
                       (in_opcode == rv_mem_pkg::OPCODE_STORE);

    // Decode of the registered bundle
    assign opcode   = inst_o[rv_mem_pkg::OPCODE_MSB:rv_mem_pkg::OPCODE_LSB];
    assign access   = rv_mem_pkg::access_t'(inst_o[rv_mem_pkg::FUNCT3_MSB:rv_mem_pkg::FUNCT3_LSB]);
    assign is_load  = (opcode == rv_mem_pkg::OPCODE_LOAD);
    assign is_store = (opcode == rv_mem_pkg::OPCODE_STORE);

    // Bundle registers are loaded only when a new bundle is taken
    always_ff @(posedge clk) begin
        if (in_hs) begin
            pc_o      <= pc_i;
            inst_o    <= inst_i;
            result_o  <= result_i;
            addr_q    <= dmem_addr_i;
            rs2_q     <= rs2_data_i;
            rd_addr_o <= rd_addr_i;
        end
        if (state == WAIT_RESP && is_load && bus.rvalid) begin
            load_data_q <= aligned_data;
        end
    end

    assign load_data_o = load_data_q;

    load_align u_load_align (
        .rdata_i  (bus.rdata),
        .offset_i (addr_q[1:0]),
        .access_i (access),
        .data_o   (aligned_data)
    );

    store_mask_gen u_store_mask_gen (
        .wdata_raw_i (rs2_q),
        .offset_i    (addr_q[1:0]),
        .access_i    (access),
        .wdata_o     (bus.wdata),
        .wstrb_o     (bus.wstrb)
    );

    // Request channels
    assign bus.awvalid = (state == REQ) && is_store && !aw_done_q;
    assign bus.wvalid  = (state == REQ) && is_store && !w_done_q;
    assign bus.arvalid = (state == REQ) && is_load;
    assign bus.awaddr  = addr_q;
    assign bus.araddr  = addr_q;
    assign bus.bready  = 1'b1;
    assign bus.rready  = 1'b1;

    // aw and w may be accepted on different cycles
    assign aw_ok = aw_done_q || (bus.awvalid && bus.awready);
    assign w_ok  = w_done_q || (bus.wvalid && bus.wready);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (in_hs) begin
                        state <= in_is_mem ? REQ : DONE;
                    end
                end
                REQ: begin
                    if (is_store) begin
                        if (aw_ok && w_ok) begin
                            state     <= WAIT_RESP;
                            aw_done_q <= 1'b0;
                            w_done_q  <= 1'b0;
                        end else begin
                            aw_done_q <= aw_ok;
                            w_done_q  <= w_ok;
                        end
                    end else if (bus.arready) begin
                        state <= WAIT_RESP;
                    end
                end
                WAIT_RESP: begin
                    if ((is_store && bus.bvalid) || (is_load && bus.rvalid)) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    if (out_ready_i) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Misaligned accesses are outside the supported set
    assign misaligned = (access inside {rv_mem_pkg::ACC_H, rv_mem_pkg::ACC_HU} && addr_q[0]) ||
                        (access == rv_mem_pkg::ACC_W && addr_q[1:0] != 2'b00);

    property hold_until_accepted(valid, ready);
        @(posedge clk) disable iff (rst) (valid && !ready) |=> valid;
    endproperty

    a_aw_hold: assert property (hold_until_accepted(bus.awvalid, bus.awready));
    a_w_hold:  assert property (hold_until_accepted(bus.wvalid, bus.wready));
    a_ar_hold: assert property (hold_until_accepted(bus.arvalid, bus.arready));

    a_aligned: assert property (@(posedge clk) disable iff (rst)
        (state == REQ) |-> !misaligned);

    // A response still on the bus means the access has not finished
    a_out_no_req: assert property (@(posedge clk) disable iff (rst)
        out_valid_o |-> !(bus.awvalid || bus.wvalid || bus.arvalid ||
                          bus.bvalid || bus.rvalid));

    // The SRAM never signals an error
    a_resp_okay: assert property (@(posedge clk) disable iff (rst)
        !(bus.bvalid && bus.bresp != axi_lite_pkg::RESP_OKAY) &&
        !(bus.rvalid && bus.rresp != axi_lite_pkg::RESP_OKAY));

endmodule

//--- lsu/store_mask_gen.sv
`timescale 1ns/1ps

module store_mask_gen (
    input  rv_mem_pkg::word_t   wdata_raw_i,
    input  logic [1:0]          offset_i,
    input  rv_mem_pkg::access_t access_i,
    output rv_mem_pkg::word_t   wdata_o,
    output axi_lite_pkg::strb_t wstrb_o
);

    // Data is copied onto every lane, the strobe picks the real ones
    always_comb begin
        case (access_i)
            rv_mem_pkg::ACC_B,
            rv_mem_pkg::ACC_BU: begin
                wdata_o = {4{wdata_raw_i[7:0]}};
                wstrb_o = axi_lite_pkg::strb_t'(4'b0001) << offset_i;
            end
            rv_mem_pkg::ACC_H,
            rv_mem_pkg::ACC_HU: begin
                wdata_o = {2{wdata_raw_i[15:0]}};
                wstrb_o = offset_i[1] ? 4'b1100 : 4'b0011;
            end
            rv_mem_pkg::ACC_W: begin
                wdata_o = wdata_raw_i;
                wstrb_o = 4'b1111;
            end
            default: begin
                // Unknown size writes nothing
                wdata_o = wdata_raw_i;
                wstrb_o = 4'b0000;
            end
        endcase
    end

endmodule

//--- lsu/load_align.sv
`timescale 1ns/1ps

module load_align (
    input  rv_mem_pkg::word_t   rdata_i,
    input  logic [1:0]          offset_i,
    input  rv_mem_pkg::access_t access_i,
    output rv_mem_pkg::word_t   data_o
);

    rv_mem_pkg::word_t shifted;
    logic [7:0]        byte_lane;
    logic [15:0]       half_lane;

    // Move the addressed lane down to bit 0
    assign shifted   = rdata_i >> {offset_i, 3'b000};
    assign byte_lane = shifted[7:0];
    assign half_lane = shifted[15:0];

    always_comb begin
        case (access_i)
            rv_mem_pkg::ACC_B: begin
                data_o = {{(rv_mem_pkg::XLEN-8){byte_lane[7]}}, byte_lane};
            end
            rv_mem_pkg::ACC_BU: begin
                data_o = {{(rv_mem_pkg::XLEN-8){1'b0}}, byte_lane};
            end
            rv_mem_pkg::ACC_H: begin
                data_o = {{(rv_mem_pkg::XLEN-16){half_lane[15]}}, half_lane};
            end
            rv_mem_pkg::ACC_HU: begin
                data_o = {{(rv_mem_pkg::XLEN-16){1'b0}}, half_lane};
            end
            rv_mem_pkg::ACC_W: begin
                data_o = rdata_i;
            end
            default: begin
                data_o = rdata_i;
            end
        endcase
    end

endmodule

//--- common/axi_lite_if.sv
`timescale 1ns/1ps

interface axi_lite_if;

    // Write address channel
    logic                 awvalid;
    logic                 awready;
    axi_lite_pkg::addr_t  awaddr;

    // Write data channel
    logic                 wvalid;
    logic                 wready;
    rv_mem_pkg::word_t    wdata;
    axi_lite_pkg::strb_t  wstrb;

    // Write response channel
    logic                 bvalid;
    logic                 bready;
    axi_lite_pkg::resp_t  bresp;

    // Read address channel
    logic                 arvalid;
    logic                 arready;
    axi_lite_pkg::addr_t  araddr;

    // Read data channel
    logic                 rvalid;
    logic                 rready;
    rv_mem_pkg::word_t    rdata;
    axi_lite_pkg::resp_t  rresp;

    modport master (
        output awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
        input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
    );

    modport slave (
        input  awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
        output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
    );

endinterface

//--- common/axi_lite_pkg.sv
package axi_lite_pkg;

    localparam int ADDR_W = 32;
    localparam int STRB_W = 4;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [1:0]        resp_t;

    localparam resp_t RESP_OKAY = 2'b00;

    // Data SRAM geometry and latency
    localparam int SRAM_WORDS      = 256;
    localparam int SRAM_READ_DELAY = 2;

endpackage

//--- common/rv_mem_pkg.sv
package rv_mem_pkg;

    // Core data and register widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [6:0]            opcode_t;
    typedef logic [2:0]            funct3_t;

    // Instruction field positions
    localparam int OPCODE_LSB = 0;
    localparam int OPCODE_MSB = 6;
    localparam int FUNCT3_LSB = 12;
    localparam int FUNCT3_MSB = 14;

    // Major opcodes for memory instructions
    localparam opcode_t OPCODE_LOAD  = 7'b0000011;
    localparam opcode_t OPCODE_STORE = 7'b0100011;

    // Access kind, encoded as funct3 of loads and stores
    typedef enum logic [2:0] {
        ACC_B  = 3'b000,
        ACC_H  = 3'b001,
        ACC_W  = 3'b010,
        ACC_BU = 3'b100,
        ACC_HU = 3'b101
    } access_t;

endpackage
